//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Register file address width
  localparam int unsigned REG_BITS = 5;

  // Major opcode field is instr[6:2]
  localparam int unsigned OPC_BITS = 5;

  // Byte distance to the next sequential instruction
  localparam int unsigned INSTR_BYTES = 4;

  // Major opcodes
  localparam logic [OPC_BITS-1:0] OP_LOAD   = 5'b00000;
  localparam logic [OPC_BITS-1:0] OP_AI     = 5'b00100; // Arithmetic with immediate
  localparam logic [OPC_BITS-1:0] OP_AUIPC  = 5'b00101;
  localparam logic [OPC_BITS-1:0] OP_STORE  = 5'b01000;
  localparam logic [OPC_BITS-1:0] OP_A      = 5'b01100; // Register-register, incl. M extension
  localparam logic [OPC_BITS-1:0] OP_LUI    = 5'b01101;
  localparam logic [OPC_BITS-1:0] OP_BRANCH = 5'b11000;
  localparam logic [OPC_BITS-1:0] OP_JALR   = 5'b11001;
  localparam logic [OPC_BITS-1:0] OP_JAL    = 5'b11011;
  localparam logic [OPC_BITS-1:0] OP_SYS    = 5'b11100; // Only mret handled here

  // Link registers per the calling convention, ra and t0
  localparam logic [REG_BITS-1:0] LINK_REG     = 5'd1;
  localparam logic [REG_BITS-1:0] LINK_REG_ALT = 5'd5;

  // Instruction formats
  // NONE covers opcodes this front end does not decode
  typedef enum logic [2:0] {
    FMT_NONE = 3'd0,
    FMT_R    = 3'd1, // Register-register
    FMT_I    = 3'd2, // Immediate, loads, jalr, system
    FMT_S    = 3'd3, // Stores
    FMT_U    = 3'd4, // Upper immediates
    FMT_B    = 3'd5, // Conditional branches
    FMT_J    = 3'd6  // jal
  } instr_fmt_e;

endpackage

`default_nettype wire

//--- design/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // Return address stack entries, keep a power of two
  localparam int unsigned RAS_DEPTH = 4;
  localparam int unsigned RAS_PTR_BITS = $clog2(RAS_DEPTH);
  localparam int unsigned RAS_CNT_BITS = $clog2(RAS_DEPTH + 1);

  // Stage 4 unit select, one-hot
  typedef enum logic [2:0] {
    PATH_ALU = 3'b001,
    PATH_MEM = 3'b010,
    PATH_MUL = 3'b100
  } stage_path_e;

  // Control bundle out of decode
  typedef struct packed {
    logic        valid;       // High one cycle per accepted instruction
    logic        imm_valid;   // imm is the second ALU operand
    logic        jal;
    logic        jalr;
    logic        branch;      // Held until resolved
    logic [2:0]  branch_cond; // funct3 of the branch
    logic        mem_write;
    logic        link;        // rd receives link_data
    logic        mret;
    logic        push_ras;
    logic        pop_ras;
    stage_path_e path;
    logic [3:0]  alu_op;      // funct7[5] then funct3
    logic [2:0]  word_size;   // funct3 of loads and stores
  } decode_ctrl_t;

  // Operand bundle out of decode
  typedef struct packed {
    logic [REG_BITS-1:0] rs1;
    logic [REG_BITS-1:0] rs2;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     pc;
    logic [XLEN-1:0]     jal_target;
    logic [XLEN-1:0]     link_data;
  } decode_ops_t;

endpackage

`default_nettype wire

//--- design/rv_imm_gen.sv
`default_nettype none

module rv_imm_gen (
  input  logic [rv_isa_pkg::XLEN-1:0] instr_i,
  input  rv_isa_pkg::instr_fmt_e      fmt_i,
  output logic [rv_isa_pkg::XLEN-1:0] imm_o
);

  import rv_isa_pkg::*;

  logic sign;
  logic [11:0] imm_i;
  logic [11:0] imm_s;
  logic [12:0] imm_b;
  logic [20:0] imm_j;

  assign sign = instr_i[31]; // Always bit 31 in RV32

  assign imm_i = instr_i[31:20];
  assign imm_s = {instr_i[31:25], instr_i[11:7]};

  // Branch and jump offsets are scattered, lsb is always zero
  assign imm_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    case (fmt_i)
      FMT_I:   imm_o = {{(XLEN-12){sign}}, imm_i};
      FMT_S:   imm_o = {{(XLEN-12){sign}}, imm_s};
      FMT_B:   imm_o = {{(XLEN-13){sign}}, imm_b};
      FMT_U:   imm_o = {instr_i[31:12], 12'b0}; // lui and auipc
      FMT_J:   imm_o = {{(XLEN-21){sign}}, imm_j};
      default: imm_o = '0; // R and unknown carry no immediate
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`default_nettype none

module rv_decode (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [rv_isa_pkg::XLEN-1:0] instr_i,
  input  logic                        instr_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
  input  logic                        irq_i,
  input  logic                        branch_resolved_i,
  output rv_pipe_pkg::decode_ctrl_t   ctrl_o,
  output rv_pipe_pkg::decode_ops_t    ops_o,
  output logic                        jump_pending_o,
  output logic [rv_isa_pkg::XLEN-1:0] uepc_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [OPC_BITS-1:0] opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [REG_BITS-1:0] rd;
  logic [REG_BITS-1:0] rs1;
  logic [REG_BITS-1:0] rs2;
  instr_fmt_e          fmt;
  logic [XLEN-1:0]     imm;
  logic                is_jal;
  logic                is_jalr;
  logic                rd_link;
  logic                rs1_link;
  decode_ctrl_t        ctrl_d;
  decode_ops_t         ops_d;

  assign opcode = instr_i[6:2];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  assign is_jal   = (opcode == OP_JAL);
  assign is_jalr  = (opcode == OP_JALR);
  assign rd_link  = (rd == LINK_REG) || (rd == LINK_REG_ALT);
  assign rs1_link = (rs1 == LINK_REG) || (rs1 == LINK_REG_ALT);

  // Anything that may redirect fetch
  assign jump_pending_o = is_jal || is_jalr || (opcode == OP_BRANCH) || (opcode == OP_SYS);

  always_comb begin
    case (opcode)
      OP_LOAD:   fmt = FMT_I;
      OP_AI:     fmt = FMT_I;
      OP_AUIPC:  fmt = FMT_U;
      OP_STORE:  fmt = FMT_S;
      OP_A:      fmt = FMT_R;
      OP_LUI:    fmt = FMT_U;
      OP_BRANCH: fmt = FMT_B;
      OP_JALR:   fmt = FMT_I;
      OP_JAL:    fmt = FMT_J;
      OP_SYS:    fmt = FMT_I; // Treated as mret
      default:   fmt = FMT_NONE;
    endcase
  end

  rv_imm_gen i_rv_imm_gen (
    .instr_i (instr_i),
    .fmt_i   (fmt),
    .imm_o   (imm)
  );

  always_comb begin
    ctrl_d = '0;
    ctrl_d.valid       = 1'b1;
    ctrl_d.imm_valid   = (fmt != FMT_R) && (fmt != FMT_B);
    ctrl_d.jal         = is_jal;
    ctrl_d.jalr        = is_jalr;
    ctrl_d.branch      = (fmt == FMT_B);
    ctrl_d.branch_cond = (fmt == FMT_B) ? funct3 : 3'b0;
    ctrl_d.mem_write   = (opcode == OP_STORE);
    ctrl_d.link        = is_jal || is_jalr;
    ctrl_d.mret        = (opcode == OP_SYS);

    // Call pushes, return pops, both at once is a coroutine swap
    ctrl_d.push_ras = rd_link && (is_jal || is_jalr);
    ctrl_d.pop_ras  = rs1_link && is_jalr && !(ctrl_d.push_ras && (rd == rs1));

    if ((opcode == OP_LOAD) || (opcode == OP_STORE))
      ctrl_d.path = PATH_MEM;
    else if ((opcode == OP_A) && funct7[0])
      ctrl_d.path = PATH_MUL; // M extension
    else
      ctrl_d.path = PATH_ALU;

    if (opcode == OP_A)
      ctrl_d.alu_op = {funct7[5], funct3};
    else if (opcode == OP_AI)
      ctrl_d.alu_op = {funct7[5] && (funct3 == 3'b101), funct3}; // srai vs srli
    else
      ctrl_d.alu_op = 4'b0;

    if ((fmt == FMT_I) || (fmt == FMT_S))
      ctrl_d.word_size = funct3;

    // Register addresses the format does not use stay zero
    ops_d = '0;
    case (fmt)
      FMT_R: begin
        ops_d.rs1 = rs1;
        ops_d.rs2 = rs2;
        ops_d.rd  = rd;
      end
      FMT_I: begin
        ops_d.rs1 = rs1;
        ops_d.rd  = rd;
      end
      FMT_S, FMT_B: begin
        ops_d.rs1 = rs1;
        ops_d.rs2 = rs2;
      end
      FMT_U, FMT_J: ops_d.rd = rd;
      default: begin
      end
    endcase

    ops_d.imm        = (opcode == OP_AUIPC) ? pc_i + imm : imm;
    ops_d.pc         = pc_i;
    ops_d.jal_target = is_jal ? pc_i + imm : ops_o.jal_target; // imm is the J offset here
    ops_d.link_data  = pc_i + XLEN'(INSTR_BYTES);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_o      <= '0;
      ctrl_o.path <= PATH_ALU;
    end else if (instr_valid_i) begin
      ctrl_o <= ctrl_d;
    end else begin
      ctrl_o.valid <= 1'b0;
      if (branch_resolved_i)
        ctrl_o.branch <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i)
      ops_o <= ops_d;
  end

  // Trap return address
  always_ff @(posedge clk_i) begin
    if (rst_i)
      uepc_o <= '0;
    else if (irq_i)
      uepc_o <= pc_i;
  end

endmodule

`default_nettype wire

//--- design/rv_ras.sv
`default_nettype none

module rv_ras (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  rv_pipe_pkg::decode_ctrl_t   ctrl_i,
  input  logic [rv_isa_pkg::XLEN-1:0] link_data_i,
  output logic [rv_isa_pkg::XLEN-1:0] ras_target_o,
  output logic                        ras_valid_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [XLEN-1:0]         entries [RAS_DEPTH];
  logic [RAS_PTR_BITS-1:0] top_q;   // Index of the most recent entry
  logic [RAS_CNT_BITS-1:0] count_q;
  logic                    do_push;
  logic                    do_pop;
  logic [RAS_PTR_BITS-1:0] wr_ptr;

  assign do_push = ctrl_i.valid && ctrl_i.push_ras;
  assign do_pop  = ctrl_i.valid && ctrl_i.pop_ras && ras_valid_o; // Empty pop ignored

  // Replace writes over the top, a plain push goes one above
  // and wraps onto the oldest entry when full
  assign wr_ptr = do_pop ? top_q : top_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (do_push)
      entries[wr_ptr] <= link_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      top_q   <= '0;
      count_q <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10: begin
          top_q <= wr_ptr;
          if (count_q != RAS_CNT_BITS'(RAS_DEPTH))
            count_q <= count_q + 1'b1;
        end
        2'b01: begin
          top_q   <= top_q - 1'b1;
          count_q <= count_q - 1'b1;
        end
        default: begin
          // Idle, or replace which keeps the depth
        end
      endcase
    end
  end

  // Top is visible in the same cycle as the pop that consumes it
  assign ras_target_o = entries[top_q];
  assign ras_valid_o  = (count_q != '0);

endmodule

`default_nettype wire

//--- design/rv_frontend.sv
`default_nettype none

module rv_frontend (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [rv_isa_pkg::XLEN-1:0] instr_i,
  input  logic                        instr_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
  input  logic                        irq_i,
  input  logic                        branch_resolved_i,
  output rv_pipe_pkg::decode_ctrl_t   ctrl_o,
  output rv_pipe_pkg::decode_ops_t    ops_o,
  output logic                        jump_pending_o,
  output logic [rv_isa_pkg::XLEN-1:0] uepc_o,
  output logic [rv_isa_pkg::XLEN-1:0] ras_target_o,
  output logic                        ras_valid_o
);

  // Decoder with its immediate builder
  rv_decode i_rv_decode (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .instr_i           (instr_i),
    .instr_valid_i     (instr_valid_i),
    .pc_i              (pc_i),
    .irq_i             (irq_i),
    .branch_resolved_i (branch_resolved_i),
    .ctrl_o            (ctrl_o),
    .ops_o             (ops_o),
    .jump_pending_o    (jump_pending_o),
    .uepc_o            (uepc_o)
  );

  // Stack follows the registered hints, one cycle behind decode
  rv_ras i_rv_ras (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ctrl_i       (ctrl_o),
    .link_data_i  (ops_o.link_data),
    .ras_target_o (ras_target_o),
    .ras_valid_o  (ras_valid_o)
  );

endmodule

`default_nettype wire

//--- bench/rv_frontend_properties.sv
`default_nettype none

module rv_frontend_properties (
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        instr_valid_i,
  input logic [rv_isa_pkg::XLEN-1:0] pc_i,
  input logic                        irq_i,
  input logic                        branch_resolved_i,
  input rv_pipe_pkg::decode_ctrl_t   ctrl_o,
  input logic [rv_isa_pkg::XLEN-1:0] uepc_o,
  input logic                        ras_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0; // Read by the testbench at the end
  logic flags_clear;

  assign flags_clear = !ctrl_o.valid && !ctrl_o.imm_valid && !ctrl_o.jal && !ctrl_o.jalr
                       && !ctrl_o.branch && (ctrl_o.branch_cond == 3'b0) && !ctrl_o.mem_write
                       && !ctrl_o.link && !ctrl_o.mret && !ctrl_o.push_ras && !ctrl_o.pop_ras;

  reset_clears: assert property (@(posedge clk_i)
    rst_i |=> flags_clear && (uepc_o == '0) && !ras_valid_o)
  else begin
    fail_count++;
    $error("Outputs not cleared one cycle after reset");
  end

  // One valid cycle per accepting edge
  valid_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_valid_i |=> ctrl_o.valid)
  else begin
    fail_count++;
    $error("ctrl valid missing after an accepted instruction");
  end

  valid_only_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
    !instr_valid_i |=> !ctrl_o.valid)
  else begin
    fail_count++;
    $error("ctrl valid high without an accepted instruction");
  end

  branch_clears: assert property (@(posedge clk_i) disable iff (rst_i)
    (!instr_valid_i && branch_resolved_i) |=> !ctrl_o.branch)
  else begin
    fail_count++;
    $error("branch still set after branch_resolved");
  end

  branch_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    (!instr_valid_i && !branch_resolved_i) |=> $stable(ctrl_o.branch))
  else begin
    fail_count++;
    $error("branch changed with no instruction and no resolve");
  end

  uepc_captures: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_i |=> (uepc_o == $past(pc_i)))
  else begin
    fail_count++;
    $error("uepc did not capture pc on interrupt");
  end

  // Stack protocol
  push_fills: assert property (@(posedge clk_i) disable iff (rst_i)
    (ctrl_o.valid && ctrl_o.push_ras) |=> ras_valid_o)
  else begin
    fail_count++;
    $error("Stack empty right after a push");
  end

  empty_stays_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    (!ras_valid_o && !(ctrl_o.valid && ctrl_o.push_ras)) |=> !ras_valid_o)
  else begin
    fail_count++;
    $error("Empty stack became valid without a push");
  end

endmodule

`default_nettype wire

//--- bench/tb_rv_frontend.sv
`default_nettype none

module tb_rv_frontend;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 2 * RESET_CYCLES; // Two resets in the run
  localparam logic [31:0] SEED = 32'h1ab4ac25;

  logic            clk;
  logic            rst;
  logic [XLEN-1:0] instr;
  logic            instr_valid;
  logic [XLEN-1:0] pc_in;
  logic            irq;
  logic            branch_resolved;
  decode_ctrl_t    ctrl;
  decode_ops_t     ops;
  logic            jump_pending;
  logic [XLEN-1:0] uepc;
  logic [XLEN-1:0] ras_target;
  logic            ras_valid;

  logic [31:0]     rng = SEED;
  int              checks;
  int              errors;
  int              tests_done;
  logic [XLEN-1:0] ref_stack [$]; // Expected return addresses with the top at the back

  rv_frontend i_rv_frontend (
    .clk_i             (clk),
    .rst_i             (rst),
    .instr_i           (instr),
    .instr_valid_i     (instr_valid),
    .pc_i              (pc_in),
    .irq_i             (irq),
    .branch_resolved_i (branch_resolved),
    .ctrl_o            (ctrl),
    .ops_o             (ops),
    .jump_pending_o    (jump_pending),
    .uepc_o            (uepc),
    .ras_target_o      (ras_target),
    .ras_valid_o       (ras_valid)
  );

  bind rv_frontend rv_frontend_properties i_rv_frontend_properties (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .instr_valid_i     (instr_valid_i),
    .pc_i              (pc_i),
    .irq_i             (irq_i),
    .branch_resolved_i (branch_resolved_i),
    .ctrl_o            (ctrl_o),
    .uepc_o            (uepc_o),
    .ras_valid_o       (ras_valid_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic draw(output logic [31:0] value);
    rng = xorshift32(rng);
    value = rng;
  endtask

  // Indices 0 to 5 carry an immediate and 4 to 6 form the classification group
  function automatic logic [4:0] opcode_at(input int idx);
    case (idx)
      0: return OP_BRANCH;
      1: return OP_LUI;
      2: return OP_AUIPC;
      3: return OP_AI;
      4: return OP_LOAD;
      5: return OP_STORE;
      6: return OP_A;
      7: return OP_JAL;
      8: return OP_JALR;
      default: return OP_SYS;
    endcase
  endfunction

  task automatic random_instr(input int first, input int count,
                              output logic [31:0] ins, output logic [31:0] pc);
    logic [31:0] r;
    draw(r);
    ins = {r[31:7], opcode_at(first + int'(r[15:8]) % count), 2'b11};
    draw(r);
    pc = {r[31:2], 2'b00}; // Word aligned
  endtask

  function automatic logic [31:0] expected_imm(input logic [31:0] ins, input logic [31:0] pc);
    case (ins[6:2])
      OP_AI, OP_LOAD, OP_JALR, OP_SYS: return $unsigned($signed(ins) >>> 20);
      OP_STORE: return ($unsigned($signed(ins) >>> 20) & 32'hffffffe0) | {27'b0, ins[11:7]};
      OP_BRANCH: return ($unsigned($signed(ins) >>> 19) & 32'hfffff000)
                        | {20'b0, ins[7], ins[30:25], ins[11:8], 1'b0};
      OP_LUI: return ins & 32'hfffff000;
      OP_AUIPC: return pc + (ins & 32'hfffff000);
      default: return 32'b0;
    endcase
  endfunction

  function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] encode_jalr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'b0, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      $display("Fail %0t ns %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Caller is at time zero or at a falling edge
  task automatic apply_reset();
    rst = 1'b1;
    instr_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  // One accepting edge and a return at the falling edge that shows the outputs
  task automatic issue(input logic [31:0] ins, input logic [31:0] pc);
    @(negedge clk);
    instr = ins;
    pc_in = pc;
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_done++;
    $display("Test %0d %s done with %0d errors", tests_done, name, errors - errors_before);
  endtask

  initial begin
    logic [31:0] ins;
    logic [31:0] pc;
    logic [31:0] r;
    logic [31:0] off;
    logic [31:0] top;
    logic [4:0]  opc;
    logic [2:0]  path_exp;
    int          base;
    int          total;

    clk = 1'b0;
    instr = '0;
    instr_valid = 1'b0;
    pc_in = '0;
    irq = 1'b0;
    branch_resolved = 1'b0;
    checks = 0;
    errors = 0;
    tests_done = 0;
    apply_reset();

    base = errors;
    compare("ctrl_o flags", 32'b0, 32'({ctrl.valid, ctrl.imm_valid, ctrl.jal, ctrl.jalr,
            ctrl.branch, ctrl.branch_cond, ctrl.mem_write, ctrl.link, ctrl.mret,
            ctrl.push_ras, ctrl.pop_ras}));
    compare("uepc_o", 32'b0, uepc);
    compare("ras_valid_o", 32'b0, 32'(ras_valid));
    end_test("reset", base);

    // Random strobes including back to back accepts
    base = errors;
    for (int i = 0; i < 60; i++) begin
      random_instr(0, 10, ins, pc);
      draw(r);
      @(negedge clk);
      instr = ins;
      pc_in = pc;
      instr_valid = r[0];
      irq = r[1] & r[2];
      branch_resolved = r[3];
    end
    @(negedge clk);
    instr_valid = 1'b0;
    irq = 1'b0;
    branch_resolved = 1'b0;
    issue(32'h00209463, 32'h80); // bne x1, x2, 8
    compare("branch", 32'd1, 32'(ctrl.branch));
    compare("branch_cond", 32'd1, 32'(ctrl.branch_cond));
    branch_resolved = 1'b1;
    @(negedge clk);
    branch_resolved = 1'b0;
    compare("branch", 32'd0, 32'(ctrl.branch));
    end_test("timing", base);

    base = errors;
    for (int i = 0; i < 40; i++) begin
      random_instr(0, 6, ins, pc);
      opc = ins[6:2];
      issue(ins, pc);
      compare("imm", expected_imm(ins, pc), ops.imm);
      compare("pc", pc, ops.pc);
      compare("rs1", (opc inside {OP_LUI, OP_AUIPC}) ? 32'b0 : 32'(ins[19:15]), 32'(ops.rs1));
      compare("rs2", (opc inside {OP_STORE, OP_BRANCH}) ? 32'(ins[24:20]) : 32'b0,
              32'(ops.rs2));
      compare("rd", (opc inside {OP_STORE, OP_BRANCH}) ? 32'b0 : 32'(ins[11:7]), 32'(ops.rd));
    end
    end_test("immediates", base);

    base = errors;
    for (int i = 0; i < 40; i++) begin
      random_instr(4, 3, ins, pc);
      opc = ins[6:2];
      issue(ins, pc);
      path_exp = (opc != OP_A) ? PATH_MEM : ins[25] ? PATH_MUL : PATH_ALU;
      compare("path", 32'(path_exp), 32'(ctrl.path));
      compare("mem_write", 32'(opc == OP_STORE), 32'(ctrl.mem_write));
      compare("alu_op", (opc == OP_A) ? 32'({ins[30], ins[14:12]}) : 32'b0, 32'(ctrl.alu_op));
      compare("word_size", (opc == OP_A) ? 32'b0 : 32'(ins[14:12]), 32'(ctrl.word_size));
      compare("imm_valid", 32'(opc != OP_A), 32'(ctrl.imm_valid));
    end
    end_test("classification", base);

    // Start from an empty stack
    base = errors;
    apply_reset();
    ref_stack.delete();
    for (int i = 1; i <= 3; i++) begin
      draw(r);
      off = {{11{r[20]}}, r[20:1], 1'b0};
      pc = 32'h1000 * i;
      issue(encode_jal(LINK_REG, off), pc);
      compare("jal", 32'd1, 32'(ctrl.jal));
      compare("link", 32'd1, 32'(ctrl.link));
      compare("jal_target", pc + off, ops.jal_target);
      compare("link_data", pc + 32'd4, ops.link_data);
      compare("push_ras", 32'd1, 32'(ctrl.push_ras));
      compare("pop_ras", 32'd0, 32'(ctrl.pop_ras));
      ref_stack.push_back(pc + 32'd4);
    end
    pc = 32'h4000;
    issue(encode_jalr(LINK_REG_ALT, LINK_REG), pc); // Swap through x5
    compare("jalr", 32'd1, 32'(ctrl.jalr));
    compare("push_ras", 32'd1, 32'(ctrl.push_ras));
    compare("pop_ras", 32'd1, 32'(ctrl.pop_ras));
    compare("link_data", pc + 32'd4, ops.link_data);
    compare("ras_target_o", ref_stack[ref_stack.size() - 1], ras_target);
    ref_stack[ref_stack.size() - 1] = pc + 32'd4;
    for (int i = 0; i < 3; i++) begin
      pc = 32'h5000 + 32'h10 * i;
      issue(encode_jalr(5'd0, LINK_REG), pc);
      top = ref_stack.pop_back();
      compare("ras_valid_o", 32'd1, 32'(ras_valid));
      compare("ras_target_o", top, ras_target);
      compare("pop_ras", 32'd1, 32'(ctrl.pop_ras));
    end
    @(negedge clk);
    compare("ras_valid_o", 32'd0, 32'(ras_valid));
    issue(encode_jalr(5'd0, LINK_REG), 32'h6000); // Nothing left to pop
    @(negedge clk);
    compare("ras_valid_o", 32'd0, 32'(ras_valid));
    end_test("jumps and stack", base);

    base = errors;
    for (int i = 0; i < 4; i++) begin
      draw(r);
      @(negedge clk);
      irq = 1'b1;
      pc_in = {r[31:2], 2'b00};
      @(negedge clk);
      irq = 1'b0;
      compare("uepc_o", {r[31:2], 2'b00}, uepc);
    end
    issue(32'h30200073, 32'h7000); // mret
    compare("mret", 32'd1, 32'(ctrl.mret));
    compare("jump_pending_o", 32'd1, 32'(jump_pending));
    issue(32'h00100093, 32'h7004); // addi x1, x0, 1
    compare("mret", 32'd0, 32'(ctrl.mret));
    compare("jump_pending_o", 32'd0, 32'(jump_pending));
    end_test("trap return", base);

    total = errors + i_rv_frontend.i_rv_frontend_properties.fail_count;
    $display("Tests %0d, checks %0d, value errors %0d, assertion errors %0d",
             tests_done, checks, errors, i_rv_frontend.i_rv_frontend_properties.fail_count);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_imm_gen.sv
design/rv_decode.sv
design/rv_ras.sv
design/rv_frontend.sv
bench/rv_frontend_properties.sv
bench/tb_rv_frontend.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_rv_frontend, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -Wno-fatal -f compile.f \
		--top-module tb_rv_frontend -Mdir obj_dir -o sim
	./obj_dir/sim +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
